/* flist.f */
+incdir+include
src/cache_pkg.sv
src/mem_wait_timer.sv
src/unified_mem.sv
src/direct_cache.sv
src/cache_controller.sv
src/mem_hierarchy_top.sv
tests/mem_hierarchy_sva.sv
tests/mem_hierarchy_tb.sv

/* include/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Processor side
`define ADDR_W      16 // Word address seen by the processor
`define WORD_W      16 // One data or instruction word

// Cache geometry, direct mapped, 64 lines of four words
`define TAG_W       8  // Upper address bits kept per line
`define IDX_W       6  // Line select
`define LINE_W      64 // Four words per line

// Backing memory
`define LINE_ADDR_W 14 // Tag and index together
`define MEM_LAT     4  // Held request cycles counted before ready

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the cache hierarchy testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module mem_hierarchy_tb \
	-o mem_hierarchy_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/mem_hierarchy_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'Done: no errors'; then
	exit 0
fi
echo "Pass message missing from simulation output"
exit 1

/* src/cache_controller.sv */
`timescale 1ns/10ps
`include "cache_settings.svh"

module cache_controller import cache_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_dacc,     // Data access request level
	input  logic        i_iacc,     // Instruction fetch request level
	input  logic        i_read,
	input  logic        i_write,
	input  word_addr_t  i_daddr,
	input  word_addr_t  i_iaddr,
	input  word_t       i_wr_data,  // Store word
	input  logic        i_d_hit,
	input  logic        i_i_hit,
	input  logic        i_d_dirty,  // Dirty bit of the indexed data line
	input  tag_t        i_d_tag,    // Tag of the indexed data line
	input  line_t       i_d_line,   // Indexed data line
	input  line_t       i_mem_line, // Read data from memory
	input  logic        i_mem_rdy,
	output mem_req_t    o_mem_req,
	output cache_fill_t o_d_fill,
	output cache_fill_t o_i_fill,
	output logic        o_rdy
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	logic       d_miss;      // Data access that is not in the data cache
	logic       i_miss;      // Fetch that is not in the instruction cache
	logic       d_store;     // Data access is a store
	logic [1:0] word_sel;    // Word of the line touched by a store
	idx_t       d_idx;
	line_addr_t d_line_addr; // Line of the data access
	line_addr_t i_line_addr; // Line of the fetch

	// Clear one word of a line and insert the store word
	function automatic line_t merge_word(input line_t line, input logic [1:0] sel,
		input word_t data);
		line_t mask;
		mask = line_t'({`WORD_W{1'b1}}) << (sel * `WORD_W); // Ones over the selected word
		return (line & ~mask) | (line_t'(data) << (sel * `WORD_W));
	endfunction

	assign d_store     = i_dacc & i_write;
	assign d_miss      = i_dacc & (i_read | i_write) & ~i_d_hit;
	assign i_miss      = i_iacc & ~i_i_hit;
	assign word_sel    = i_daddr[1:0];
	assign d_idx       = i_daddr[`IDX_W+1:2];
	assign d_line_addr = i_daddr[`ADDR_W-1:2];
	assign i_line_addr = i_iaddr[`ADDR_W-1:2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		o_mem_req = '0; // No memory traffic unless a state asks
		o_d_fill  = '0;
		o_i_fill  = '0;
		o_rdy     = 1'b0;

		case (state)
			IDLE: begin
				if (d_miss) begin // Data miss wins over a fetch miss
					state_nxt = i_d_dirty ? WRITE_BACK : REFILL; // Dirty victim goes out first
				end else if (i_miss) begin
					state_nxt = REFILL;
				end else begin // Both sides hit or idle
					o_rdy = 1'b1;
					if (d_store) begin // Store hit updates the line in place
						o_d_fill.we    = 1'b1;
						o_d_fill.dirty = 1'b1;
						o_d_fill.data  = merge_word(i_d_line, word_sel, i_wr_data);
					end
				end
			end

			WRITE_BACK: begin
				o_mem_req.we    = 1'b1;
				o_mem_req.addr  = {i_d_tag, d_idx}; // Victim line address
				o_mem_req.wdata = i_d_line;
				if (i_mem_rdy) begin // Victim stored on this edge
					state_nxt = FETCH_GAP;
				end
			end

			FETCH_GAP: begin
				o_mem_req.re   = 1'b1; // Timer starts a fresh count
				o_mem_req.addr = d_line_addr;
				state_nxt      = REFILL;
			end

			REFILL: begin
				o_mem_req.re   = 1'b1;
				o_mem_req.addr = d_miss ? d_line_addr : i_line_addr; // Data miss served first
				if (i_mem_rdy) begin
					state_nxt = IDLE; // Line hits on the next cycle
					if (d_miss) begin
						o_d_fill.we = 1'b1;
						if (d_store) begin // Write-allocate, merge store into new line
							o_d_fill.dirty = 1'b1;
							o_d_fill.data  = merge_word(i_mem_line, word_sel, i_wr_data);
						end else begin
							o_d_fill.data = i_mem_line;
						end
					end else begin
						o_i_fill.we   = 1'b1; // Instruction lines are never dirty
						o_i_fill.data = i_mem_line;
					end
				end
			end

			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

endmodule

/* src/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

	typedef logic [`ADDR_W-1:0]      word_addr_t; // Tag, index, word select
	typedef logic [`LINE_ADDR_W-1:0] line_addr_t; // Tag followed by index
	typedef logic [`TAG_W-1:0]       tag_t;
	typedef logic [`IDX_W-1:0]       idx_t;
	typedef logic [`WORD_W-1:0]      word_t;
	typedef logic [`LINE_W-1:0]      line_t;      // Word 0 in the low bits

	// Miss handling states
	typedef enum logic [1:0] {
		IDLE,       // Serve hits, detect misses
		FETCH_GAP,  // Start the refill read after a write-back
		REFILL,     // Wait for the missing line
		WRITE_BACK  // Store the dirty victim line
	} ctrl_state_t;

	typedef struct packed {
		logic       re;    // Line read
		logic       we;    // Line write
		line_addr_t addr;  // Line address
		line_t      wdata; // Victim line on a write-back
	} mem_req_t;

	typedef struct packed {
		logic  we;    // Store line, tag and valid this edge
		logic  dirty; // New dirty bit of the line
		line_t data;  // New line contents
	} cache_fill_t;

endpackage

/* src/direct_cache.sv */
`timescale 1ns/10ps
`include "cache_settings.svh"

module direct_cache import cache_pkg::*; #(
	parameter bit WRITE_BACK_EN = 1'b0 // 1 keeps a dirty bit per line
) (
	input  logic        clk,
	input  logic        rst_n,
	input  word_addr_t  i_addr,
	input  cache_fill_t i_fill,  // Line write from the controller
	output logic        o_hit,
	output line_t       o_line,  // Indexed line, hit or not
	output tag_t        o_tag,   // Stored tag of the indexed line
	output logic        o_dirty,
	output word_t       o_word   // Word picked by address bits 1:0
);

	localparam int DEPTH = 1 << `IDX_W;

	tag_t             tag_mem  [DEPTH];
	line_t            data_mem [DEPTH];
	logic [DEPTH-1:0] valid;

	tag_t       addr_tag;
	idx_t       addr_idx;
	logic [1:0] word_sel;

	assign addr_tag = i_addr[`ADDR_W-1 -: `TAG_W];
	assign addr_idx = i_addr[`IDX_W+1:2];
	assign word_sel = i_addr[1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0; // Empty cache
		end else if (i_fill.we) begin
			valid[addr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_fill.we) begin
			tag_mem[addr_idx]  <= addr_tag;
			data_mem[addr_idx] <= i_fill.data;
		end
	end

	generate
		if (WRITE_BACK_EN) begin : g_dirty
			logic [DEPTH-1:0] dirty_bits;

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					dirty_bits <= '0;
				end else if (i_fill.we) begin
					dirty_bits[addr_idx] <= i_fill.dirty;
				end
			end

			assign o_dirty = dirty_bits[addr_idx]; // Victim test, valid not needed
		end else begin : g_no_dirty
			assign o_dirty = 1'b0; // Read-only cache
		end
	endgenerate

	assign o_line = data_mem[addr_idx];
	assign o_tag  = tag_mem[addr_idx];
	assign o_hit  = valid[addr_idx] && (tag_mem[addr_idx] == addr_tag);
	assign o_word = o_line[word_sel * `WORD_W +: `WORD_W];

endmodule

/* src/mem_hierarchy_top.sv */
`timescale 1ns/10ps

module mem_hierarchy_top import cache_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_iacc,
	input  word_addr_t i_iaddr,
	input  logic       i_dacc,
	input  word_addr_t i_daddr,
	input  logic       i_read,
	input  logic       i_write,
	input  word_t      i_wr_data,
	output logic       o_rdy,     // Both requests complete
	output word_t      o_instr,
	output word_t      o_rd_data
);

	mem_req_t    mem_req;
	line_t       mem_line;
	logic        mem_rdy;
	cache_fill_t d_fill;
	cache_fill_t i_fill;
	logic        d_hit;
	logic        i_hit;
	logic        d_dirty;
	tag_t        d_tag;
	line_t       d_line;

	cache_controller cache_controller_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_dacc     (i_dacc),
		.i_iacc     (i_iacc),
		.i_read     (i_read),
		.i_write    (i_write),
		.i_daddr    (i_daddr),
		.i_iaddr    (i_iaddr),
		.i_wr_data  (i_wr_data),
		.i_d_hit    (d_hit),
		.i_i_hit    (i_hit),
		.i_d_dirty  (d_dirty),
		.i_d_tag    (d_tag),
		.i_d_line   (d_line),
		.i_mem_line (mem_line),
		.i_mem_rdy  (mem_rdy),
		.o_mem_req  (mem_req),
		.o_d_fill   (d_fill),
		.o_i_fill   (i_fill),
		.o_rdy      (o_rdy)
	);

	direct_cache #(.WRITE_BACK_EN(1'b0)) icache_i ( // Read-only
		.clk     (clk),
		.rst_n   (rst_n),
		.i_addr  (i_iaddr),
		.i_fill  (i_fill),
		.o_hit   (i_hit),
		.o_line  (),
		.o_tag   (),
		.o_dirty (),
		.o_word  (o_instr)
	);

	direct_cache #(.WRITE_BACK_EN(1'b1)) dcache_i ( // Write-back
		.clk     (clk),
		.rst_n   (rst_n),
		.i_addr  (i_daddr),
		.i_fill  (d_fill),
		.o_hit   (d_hit),
		.o_line  (d_line),
		.o_tag   (d_tag),
		.o_dirty (d_dirty),
		.o_word  (o_rd_data)
	);

	unified_mem unified_mem_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_req  (mem_req),
		.o_line (mem_line),
		.o_rdy  (mem_rdy)
	);

endmodule

/* src/mem_wait_timer.sv */
`timescale 1ns/10ps
`include "cache_settings.svh"

module mem_wait_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic i_busy, // Memory request held
	output logic o_done  // One cycle ready strobe
);

	localparam int CNT_W = $clog2(`MEM_LAT + 1);

	logic [CNT_W-1:0] cnt; // Held cycles so far

	// Strobe once the count reaches the latency
	assign o_done = i_busy && (cnt == CNT_W'(`MEM_LAT));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!i_busy || o_done) begin
			cnt <= '0; // Idle or finished, next request counts from zero
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

/* src/unified_mem.sv */
`timescale 1ns/10ps
`include "cache_settings.svh"

module unified_mem import cache_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t i_req,  // Held until o_rdy
	output line_t    o_line, // Addressed line, valid with o_rdy on reads
	output logic     o_rdy
);

	localparam int LINES = 1 << `LINE_ADDR_W;

	line_t mem [LINES];
	logic  busy;

	// Model starts out all zero
	initial begin
		for (int i = 0; i < LINES; i++) begin
			mem[i] = '0;
		end
	end

	assign busy = i_req.re | i_req.we;

	mem_wait_timer wait_timer_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_busy (busy),
		.o_done (o_rdy)
	);

	always_ff @(posedge clk) begin
		if (i_req.we && o_rdy) begin // Write lands at the end of the latency
			mem[i_req.addr] <= i_req.wdata;
		end
	end

	assign o_line = mem[i_req.addr]; // Combinational read

endmodule

/* tests/mem_hierarchy_sva.sv */
`timescale 1ns/10ps

module mem_hierarchy_sva import cache_pkg::*; (
	input logic        clk,
	input logic        rst_n,
	input ctrl_state_t i_state,
	input mem_req_t    i_mem_req,
	input logic        i_mem_rdy,
	input cache_fill_t i_d_fill,
	input cache_fill_t i_i_fill,
	input logic        i_d_store
);

	// Memory sees one operation at a time
	a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_mem_req.re && i_mem_req.we))
		else $error("Memory read and write requested in the same cycle");

	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(i_mem_req.re || i_mem_req.we) && !i_mem_rdy |=> $stable(i_mem_req))
		else $error("Memory request changed before the ready strobe"); // Held until ready

	// Lines are written on a refill or by a store hit
	a_fill_timing: assert property (@(posedge clk) disable iff (!rst_n)
		(i_d_fill.we || i_i_fill.we) |-> i_mem_rdy || (i_state == IDLE && i_d_store))
		else $error("Cache fill outside a ready cycle or a store hit");

endmodule

bind cache_controller mem_hierarchy_sva mem_hierarchy_sva_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.i_state   (state),
	.i_mem_req (o_mem_req),
	.i_mem_rdy (i_mem_rdy),
	.i_d_fill  (o_d_fill),
	.i_i_fill  (o_i_fill),
	.i_d_store (d_store)
);

/* tests/mem_hierarchy_tb.sv */
`timescale 1ns/10ps
`include "cache_settings.svh"

module mem_hierarchy_tb import cache_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int NUM_DIRECT = 15;
	localparam int NUM_RANDOM = 300;
	localparam int WORST_CYC  = 2 * (2 * `MEM_LAT + 4); // Dirty data miss and fetch miss together
	localparam int LIMIT_CYC  = (NUM_DIRECT + NUM_RANDOM) * WORST_CYC + 50;
	localparam int LINES      = 1 << `IDX_W;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	typedef struct packed {
		int    cycles; // Edges from request to o_rdy
		logic  chk_i;  // Fetch result valid
		word_t instr;
		logic  chk_d;  // Load result valid
		word_t data;
	} expect_t;

	logic        clk;
	logic        rst_n;
	logic        i_iacc;
	word_addr_t  i_iaddr;
	logic        i_dacc;
	word_addr_t  i_daddr;
	logic        i_read;
	logic        i_write;
	word_t       i_wr_data;
	logic        o_rdy;
	word_t       o_instr;
	word_t       o_rd_data;
	logic [31:0] lfsr;
	expect_t     expected[$]; // Results waiting for o_rdy
	int          issued;
	int          done_cnt;

	line_t ref_mem [line_addr_t]; // Lines never written read as zero
	logic  d_valid [LINES];
	logic  d_dirty [LINES];
	tag_t  d_tag   [LINES];
	line_t d_data  [LINES];
	logic  i_valid [LINES];
	tag_t  i_tag   [LINES];
	line_t i_data  [LINES];

	mem_hierarchy_top mem_hierarchy_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_iacc    (i_iacc),
		.i_iaddr   (i_iaddr),
		.i_dacc    (i_dacc),
		.i_daddr   (i_daddr),
		.i_read    (i_read),
		.i_write   (i_write),
		.i_wr_data (i_wr_data),
		.o_rdy     (o_rdy),
		.o_instr   (o_instr),
		.o_rd_data (o_rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int k = 0; k < n; k++) begin
			b    = lfsr[0];
			lfsr = (lfsr >> 1) ^ (b ? LFSR_TAPS : 32'h0);
			r    = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic word_addr_t mk_addr(input tag_t tag, input idx_t idx, input logic [1:0] w);
		return {tag, idx, w};
	endfunction

	function automatic line_t mem_line(input line_addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : '0;
	endfunction

	// Predicts words and cycle count and updates the model caches and memory
	function automatic expect_t predict(input logic iacc, input word_addr_t iaddr,
		input logic dacc, input word_addr_t daddr, input logic wr, input word_t wdata);
		expect_t e;
		idx_t    di;
		idx_t    ii;
		tag_t    dt;
		tag_t    it;
		int      dws;
		int      iws;
		di  = daddr[`IDX_W+1:2];
		ii  = iaddr[`IDX_W+1:2];
		dt  = daddr[`ADDR_W-1 -: `TAG_W];
		it  = iaddr[`ADDR_W-1 -: `TAG_W];
		dws = int'(daddr[1:0]) * `WORD_W;
		iws = int'(iaddr[1:0]) * `WORD_W;
		e   = '0;
		if (dacc) begin // Data side is served first
			if (!(d_valid[di] && d_tag[di] == dt)) begin
				if (d_dirty[di]) begin
					ref_mem[{d_tag[di], di}] = d_data[di]; // Victim reaches memory
					e.cycles += 2 * `MEM_LAT + 3;
				end else begin
					e.cycles += `MEM_LAT + 2;
				end
				d_valid[di] = 1'b1;
				d_tag[di]   = dt;
				d_dirty[di] = 1'b0;
				d_data[di]  = mem_line({dt, di});
			end
			if (wr) begin
				d_data[di][dws +: `WORD_W] = wdata; // Only the addressed word changes
				d_dirty[di] = 1'b1;
			end else begin
				e.chk_d = 1'b1;
				e.data  = d_data[di][dws +: `WORD_W];
			end
		end
		if (iacc) begin
			if (!(i_valid[ii] && i_tag[ii] == it)) begin
				e.cycles += `MEM_LAT + 2;
				i_valid[ii] = 1'b1;
				i_tag[ii]   = it;
				i_data[ii]  = mem_line({it, ii}); // Sees memory and not dirty data lines
			end
			e.chk_i = 1'b1;
			e.instr = i_data[ii][iws +: `WORD_W];
		end
		return e;
	endfunction

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			$display("** Error: cycles to o_rdy = 0x%0h, expected 0x%0h", got, exp);
			abort_run();
		end
	endtask

	// One access held until the DUT answers
	task automatic do_access(input logic iacc, input word_addr_t iaddr, input logic dacc,
		input word_addr_t daddr, input logic wr, input word_t wdata);
		expected.push_back(predict(iacc, iaddr, dacc, daddr, wr, wdata));
		issued++;
		i_iacc    = iacc;
		i_iaddr   = iaddr;
		i_dacc    = dacc;
		i_daddr   = daddr;
		i_read    = dacc & ~wr;
		i_write   = dacc & wr;
		i_wr_data = wdata;
		wait (done_cnt == issued);
		@(posedge clk); // Completing edge
		#10;
	endtask

	initial begin : compare_results
		expect_t e;
		int      cycles;
		cycles = 0;
		forever begin
			@(negedge clk); // Outputs settled mid cycle
			if (expected.size() != 0) begin
				if (o_rdy) begin
					e = expected.pop_front();
					check_latency(cycles, e.cycles);
					if (e.chk_i) begin
						check_word("o_instr", o_instr, e.instr);
					end
					if (e.chk_d) begin
						check_word("o_rd_data", o_rd_data, e.data);
					end
					cycles = 0;
					done_cnt++;
				end else begin
					cycles++;
				end
			end
		end
	end

	initial begin : watchdog
		#(LIMIT_CYC * CLK_PERIOD);
		$display("Timeout: the accesses did not finish within %0d cycles", LIMIT_CYC);
		abort_run();
	end

	initial begin : stimulus
		logic       iacc;
		logic       dacc;
		logic       wr;
		word_addr_t iaddr;
		word_addr_t daddr;
		word_t      wdata;
		lfsr      = 32'h3562951e;
		issued    = 0;
		done_cnt  = 0;
		rst_n     = 1'b0;
		i_iacc    = 1'b0;
		i_iaddr   = '0;
		i_dacc    = 1'b0;
		i_daddr   = '0;
		i_read    = 1'b0;
		i_write   = 1'b0;
		i_wr_data = '0;
		for (int k = 0; k < LINES; k++) begin // Model caches start empty
			d_valid[k] = 1'b0;
			d_dirty[k] = 1'b0;
			i_valid[k] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#10;
		rst_n = 1'b1;

		do_access(1'b0, '0, 1'b1, mk_addr(8'd1, 6'd5, 2'd0), 1'b0, 16'h0); // Cold miss
		do_access(1'b0, '0, 1'b1, mk_addr(8'd1, 6'd5, 2'd0), 1'b0, 16'h0); // Same line hits
		do_access(1'b0, '0, 1'b1, mk_addr(8'd1, 6'd5, 2'd1), 1'b1, 16'h7777); // Nonzero neighbour
		do_access(1'b0, '0, 1'b1, mk_addr(8'd1, 6'd5, 2'd2), 1'b1, 16'hbeef); // Store hit
		do_access(1'b0, '0, 1'b1, mk_addr(8'd1, 6'd5, 2'd0), 1'b0, 16'h0);
		do_access(1'b0, '0, 1'b1, mk_addr(8'd1, 6'd5, 2'd1), 1'b0, 16'h0);
		do_access(1'b0, '0, 1'b1, mk_addr(8'd1, 6'd5, 2'd3), 1'b0, 16'h0);
		do_access(1'b0, '0, 1'b1, mk_addr(8'd1, 6'd5, 2'd2), 1'b0, 16'h0);
		do_access(1'b0, '0, 1'b1, mk_addr(8'd2, 6'd5, 2'd1), 1'b1, 16'h1234); // Dirty evict
		do_access(1'b0, '0, 1'b1, mk_addr(8'd1, 6'd5, 2'd2), 1'b0, 16'h0); // From memory
		do_access(1'b1, mk_addr(8'd0, 6'd9, 2'd3), 1'b0, '0, 1'b0, 16'h0); // Fetch miss
		do_access(1'b1, mk_addr(8'd3, 6'd10, 2'd0), 1'b1, mk_addr(8'd3, 6'd11, 2'd1),
			1'b0, 16'h0); // Both miss
		do_access(1'b0, '0, 1'b1, mk_addr(8'd0, 6'd20, 2'd0), 1'b1, 16'h5a5a);
		do_access(1'b1, mk_addr(8'd0, 6'd20, 2'd0), 1'b0, '0, 1'b0, 16'h0); // Stale fetch
		do_access(1'b1, mk_addr(8'd0, 6'd20, 2'd0), 1'b1, mk_addr(8'd0, 6'd20, 2'd0),
			1'b0, 16'h0); // Both hit with caches that disagree

		for (int n = 0; n < NUM_RANDOM; n++) begin // Four tags over eight lines
			iacc  = 1'(rand_bits(1));
			dacc  = 1'(rand_bits(1));
			wr    = 1'(rand_bits(1));
			iaddr = mk_addr(tag_t'(rand_bits(2)), idx_t'(rand_bits(3)), 2'(rand_bits(2)));
			daddr = mk_addr(tag_t'(rand_bits(2)), idx_t'(rand_bits(3)), 2'(rand_bits(2)));
			wdata = word_t'(rand_bits(16));
			do_access(iacc, iaddr, dacc, daddr, wr, wdata);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule
